/* filelist.f */
common/ldpc_enc_pkg.sv
hw/enc_buf/ldpc_enc_buf_ram.sv
hw/enc_buf/ldpc_enc_raddr_gen.sv
hw/ldpc_enc_credit_cnt.sv
hw/ldpc_enc_ctrl.sv
hw/ldpc_enc_slicer.sv
hw/ldpc_enc_src.sv
testbench/ldpc_enc_src_chk.sv
testbench/tb_ldpc_enc_src.sv

/* testbench/tb_ldpc_enc_src.sv */
// Testbench for the LDPC encoder input buffer read side.
// Loads random frames with random input gaps, returns credits after random
// delays and checks every slice against a model of the slicing rule.

`timescale 1ns/1ps

module tb_ldpc_enc_src;

  import ldpc_enc_pkg::*;

  localparam int credits    = 4;
  localparam int num_frames = 20;
  localparam int max_words  = 16;
  localparam int stall_len  = 60;  // Cycles the consumer sits on its credits.
  localparam int cyc_limit  = num_frames * max_words * 8 * 8 + 1000;

  logic       iclk;
  logic       arst_n;
  logic       start;
  frame_cfg_t cfg;
  in_word_t   in_word;
  logic       credit_ret;
  out_slice_t out_slice;
  logic       busy;

  integer     seed;
  int         err_cnt;
  int         chk_cnt;
  int         cycles;
  int         emitted;          // Slices seen on the output.
  int         returned;         // Credits handed back.
  int         pending;          // Slices seen but not yet credited back.
  int         delay_cnt;
  int         stall_cnt;
  logic       stall_req;        // This frame gets a long credit stall.
  logic [8:0] exp_q [$];        // Expected {last, data} per slice.
  int         delay_tab [4096]; // Credit return delays, drawn up front.

  ldpc_enc_src #(
    .addr_w        (8),
    .use_var_dat_w (1),
    .credits       (credits)
  ) u_dut (
    .iclk       (iclk),
    .arst_n     (arst_n),
    .start      (start),
    .cfg        (cfg),
    .in_word    (in_word),
    .credit_ret (credit_ret),
    .out_slice  (out_slice),
    .busy       (busy)
  );

  always #10 iclk = ~iclk;  // 20 ns period.

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  // Slice idx of a word, width bits taken from the low end upward.
  function automatic logic [7:0] slice_of(input logic [7:0] word, input int width,
                                          input int idx);
    logic [7:0] mask;
    mask = 8'((1 << width) - 1);
    return (word >> (idx * width)) & mask;
  endfunction

  // Output monitor and credit return for the consumer side.
  always @(negedge iclk) begin : consumer
    logic [8:0] exp_slice;
    credit_ret = 1'b0;
    if (arst_n && out_slice.valid) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Error: a slice came out when none was expected at %0t", $time);
      end else begin
        exp_slice = exp_q.pop_front();
        compare_value("out_slice.data", out_slice.data, exp_slice[7:0]);
        compare_value("out_slice.last", out_slice.last, exp_slice[8]);
      end
      emitted++;
      pending++;
      compare_value("outstanding_ok", (emitted - returned <= credits), 1);
    end
    if (stall_req && pending > 0 && stall_cnt < stall_len) begin
      stall_cnt++;  // Output has to stop once all credits are held.
    end else if (pending > 0) begin
      if (delay_cnt == 0) begin
        credit_ret = 1'b1;
        pending--;
        returned++;
        delay_cnt = delay_tab[returned % 4096];
      end else begin
        delay_cnt--;
      end
    end
    if (!stall_req) begin
      stall_cnt = 0;
    end
  end

  // Timeout guard, counted in clock cycles.
  initial begin
    cycles = 0;
    while (cycles < cyc_limit) begin
      @(posedge iclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cyc_limit);
    $display("Checks: %0d, errors: %0d, slices: %0d", chk_cnt, err_cnt + 1, emitted);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int         nwords;
    int         width;
    int         gap;
    logic       last;
    logic [7:0] words [max_words];
    iclk       = 1'b0;
    arst_n     = 1'b0;
    start      = 1'b0;
    cfg        = '0;
    in_word    = '0;
    credit_ret = 1'b0;
    err_cnt    = 0;
    chk_cnt    = 0;
    emitted    = 0;
    returned   = 0;
    pending    = 0;
    delay_cnt  = 0;
    stall_cnt  = 0;
    stall_req  = 1'b0;
    seed       = 32'h900b_9b08;
    for (int i = 0; i < 4096; i++) begin
      delay_tab[i] = {$random(seed)} % 6;  // Zero to five cycles.
    end
    repeat (16) @(posedge iclk);
    @(negedge iclk);
    arst_n = 1'b1;
    compare_value("out_slice.valid", out_slice.valid, 0);
    compare_value("busy", busy, 0);

    for (int fi = 0; fi < num_frames; fi++) begin
      // The next frame starts only once the previous one has fully drained.
      @(posedge iclk);
      while (busy || exp_q.size() != 0) begin
        @(posedge iclk);
      end
      nwords = 1 + ({$random(seed)} % max_words);
      if (fi == 0) begin
        width = 8;
      end else if (fi == 1) begin
        width = 1;
      end else begin
        width = 1 << ({$random(seed)} % 4);
      end
      stall_req = (fi % 5 == 3);
      for (int w = 0; w < nwords; w++) begin
        words[w] = 8'($random(seed));
        for (int k = 0; k < 8 / width; k++) begin
          last = (w == nwords - 1) && (k == 8 / width - 1);
          exp_q.push_back({last, slice_of(words[w], width, k)});
        end
      end
      @(negedge iclk);
      start         = 1'b1;
      cfg.num_words = 8'(nwords);
      cfg.used_w    = used_w_t'(width);
      @(negedge iclk);
      start = 1'b0;
      compare_value("busy", busy, 1);
      for (int w = 0; w < nwords; w++) begin
        gap = {$random(seed)} % 4;
        repeat (gap) @(negedge iclk);  // Idle input cycles.
        in_word.valid = 1'b1;
        in_word.data  = words[w];
        @(negedge iclk);
        in_word = '0;
      end
    end

    @(posedge iclk);
    while (busy || pending != 0) begin
      @(posedge iclk);
    end
    repeat (10) @(posedge iclk);  // Room for slices still in flight and any stray one.
    compare_value("expected slices left", exp_q.size(), 0);
    compare_value("busy", busy, 0);

    $display("Checks: %0d, errors: %0d, slices: %0d", chk_cnt, err_cnt, emitted);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* testbench/ldpc_enc_src_chk.sv */
// Assertion checker for the encoder input buffer top level.
// Tracks slices that left the block and were not yet credited back, and
// flags output outside the credit window or before the first frame start.

`timescale 1ns/1ps

module ldpc_enc_src_chk #(
  parameter int credits = 4
) (
  input logic                     iclk,
  input logic                     arst_n,
  input logic                     start,
  input logic                     credit_ret,
  input ldpc_enc_pkg::out_slice_t out_slice,
  input logic                     busy
);

  int   unret;    // Slices emitted and not yet returned.
  logic started;  // A frame start was seen since reset.

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      unret   <= 0;
      started <= 1'b0;
    end else begin
      unret <= unret + int'(out_slice.valid) - int'(credit_ret);
      if (start) begin
        started <= 1'b1;
      end
    end
  end

  // The slice now on the output adds one to the unreturned count.
  a_credit_limit: assert property (@(posedge iclk) disable iff (!arst_n)
    out_slice.valid |-> (unret < credits))
    else $error("Slice emitted while %0d slices were already unreturned", unret);

  a_no_early_out: assert property (@(posedge iclk) disable iff (!arst_n)
    !started |-> !out_slice.valid)
    else $error("Slice emitted before any frame start");

  a_idle_after_reset: assert property (@(posedge iclk) disable iff (!arst_n)
    !started |-> !busy)
    else $error("Busy raised before any frame start");

endmodule

bind ldpc_enc_src ldpc_enc_src_chk #(
  .credits (credits)
) u_chk (
  .iclk       (iclk),
  .arst_n     (arst_n),
  .start      (start),
  .credit_ret (credit_ret),
  .out_slice  (out_slice),
  .busy       (busy)
);

/* hw/ldpc_enc_src.sv */
// Top level of the LDPC encoder input buffer read side.
// A frame is loaded into the buffer RAM and read back as a slice stream
// under credit flow control. Each slice leaves three cycles after its read.

`timescale 1ns/1ps

module ldpc_enc_src #(
  parameter int addr_w        = 8,
  parameter bit use_var_dat_w = 1,
  parameter int credits       = 4
) (
  input  logic                     iclk,
  input  logic                     arst_n,
  input  logic                     start,
  input  ldpc_enc_pkg::frame_cfg_t cfg,
  input  ldpc_enc_pkg::in_word_t   in_word,
  input  logic                     credit_ret,
  output ldpc_enc_pkg::out_slice_t out_slice,
  output logic                     busy
);

  import ldpc_enc_pkg::*;

  logic              wr_en;        // Buffer write strobe.
  logic [addr_w-1:0] wr_addr;
  logic [dat_w-1:0]  wr_data;
  logic              rd_clear;     // Rewinds the read address.
  logic              rd_enable;    // One slice read.
  logic              rd_last;      // Marks the final slice read.
  logic              consume;
  logic              avail;        // At least one credit is free.
  used_w_t           used_w;       // Slice width of the current frame.
  logic [addr_w-1:0] raddr;
  logic [dat_w-1:0]  rdata;
  logic              rval;
  logic              rlast;
  logic              rword_start;

  ldpc_enc_ctrl #(
    .addr_w (addr_w)
  ) u_ctrl (
    .iclk      (iclk),
    .arst_n    (arst_n),
    .start     (start),
    .cfg       (cfg),
    .in_word   (in_word),
    .avail     (avail),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clear  (rd_clear),
    .rd_enable (rd_enable),
    .rd_last   (rd_last),
    .consume   (consume),
    .used_w    (used_w),
    .busy      (busy)
  );

  ldpc_enc_credit_cnt #(
    .credits (credits)
  ) u_credit_cnt (
    .iclk       (iclk),
    .arst_n     (arst_n),
    .consume    (consume),
    .credit_ret (credit_ret),
    .avail      (avail)
  );

  ldpc_enc_buf_ram #(
    .addr_w (addr_w)
  ) u_buf_ram (
    .iclk    (iclk),
    .arst_n  (arst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .raddr   (raddr),
    .rdata   (rdata)
  );

  ldpc_enc_raddr_gen #(
    .addr_w        (addr_w),
    .use_var_dat_w (use_var_dat_w)
  ) u_raddr_gen (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .used_w      (used_w),
    .rd_clear    (rd_clear),
    .rd_enable   (rd_enable),
    .rd_last     (rd_last),
    .raddr       (raddr),
    .rval        (rval),
    .rlast       (rlast),
    .rword_start (rword_start)
  );

  ldpc_enc_slicer u_slicer (
    .iclk        (iclk),
    .arst_n      (arst_n),
    .rdata       (rdata),
    .rval        (rval),
    .rlast       (rlast),
    .rword_start (rword_start),
    .used_w      (used_w),
    .out_slice   (out_slice)
  );

endmodule

/* hw/ldpc_enc_slicer.sv */
// Slicer for the encoder input stream.
// Cuts each word read from the buffer RAM into slices of used_w bits,
// least significant bits first, and drives the output slice struct.

`timescale 1ns/1ps

module ldpc_enc_slicer (
  input  logic                           iclk,
  input  logic                           arst_n,
  input  logic [ldpc_enc_pkg::dat_w-1:0] rdata,
  input  logic                           rval,
  input  logic                           rlast,
  input  logic                           rword_start,
  input  ldpc_enc_pkg::used_w_t          used_w,
  output ldpc_enc_pkg::out_slice_t       out_slice
);

  import ldpc_enc_pkg::*;

  logic [dat_w-1:0] src;    // Word the current slice comes from.
  logic [dat_w-1:0] hold;   // Remaining bits of the current word.
  logic [dat_w-1:0] mask;   // Low used_w bits set.
  logic [dat_w-1:0] data_q;
  logic             val_q;
  logic             last_q;

  // A fresh word comes straight from the RAM, later slices from hold.
  assign src  = rword_start ? rdata : hold;
  assign mask = ~({dat_w{1'b1}} << used_w);  // All ones for a width of 8.

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      val_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      val_q  <= rval;
      last_q <= rval & rlast;
    end
  end

  // Slice data and the shift register only move on a valid read.
  always_ff @(posedge iclk) begin
    if (rval) begin
      data_q <= src & mask;       // Upper bits forced to zero.
      hold   <= src >> used_w;    // Next slice moves to the bottom.
    end
  end

  always_comb begin
    out_slice.valid = val_q;
    out_slice.last  = last_q;
    out_slice.data  = data_q;
  end

endmodule

/* hw/ldpc_enc_ctrl.sv */
// Frame controller of the encoder input buffer.
// Loads a frame of words into the buffer RAM, then issues one read per
// slice while credits allow, and flags the final slice of the frame.

`timescale 1ns/1ps

module ldpc_enc_ctrl #(
  parameter int addr_w = 8
) (
  input  logic                           iclk,
  input  logic                           arst_n,
  input  logic                           start,
  input  ldpc_enc_pkg::frame_cfg_t       cfg,
  input  ldpc_enc_pkg::in_word_t         in_word,
  input  logic                           avail,
  output logic                           wr_en,
  output logic [addr_w-1:0]              wr_addr,
  output logic [ldpc_enc_pkg::dat_w-1:0] wr_data,
  output logic                           rd_clear,
  output logic                           rd_enable,
  output logic                           rd_last,
  output logic                           consume,
  output ldpc_enc_pkg::used_w_t          used_w,
  output logic                           busy
);

  import ldpc_enc_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_read
  } state_t;

  state_t     state;
  frame_cfg_t cfg_q;      // Frame setup held for the whole frame.
  logic [7:0] wcnt;       // Words written so far.
  logic [11:0] scnt;      // Slices issued so far.
  logic [8:0]  nwords;    // Frame length with 0 read as 256.
  logic [11:0] total;     // Slices in the frame.
  logic        last_word; // The word counter points at the final word.

  assign nwords = (cfg_q.num_words == '0) ? 9'd256 : {1'b0, cfg_q.num_words};

  // Slices per frame are words times dat_w over the slice width.
  always_comb begin
    case (cfg_q.used_w)
      4'd1:    total = {nwords, 3'b000};
      4'd2:    total = {1'b0, nwords, 2'b00};
      4'd4:    total = {2'b00, nwords, 1'b0};
      default: total = {3'b000, nwords};
    endcase
  end

  // The byte wrap makes 0 minus 1 equal 255, which covers 256 words.
  assign last_word = (wcnt == cfg_q.num_words - 8'd1);

  assign wr_en     = (state == st_load) & in_word.valid;
  assign wr_addr   = addr_w'(wcnt);
  assign wr_data   = in_word.data;
  assign rd_clear  = wr_en & last_word;  // Pulses together with the final write.
  assign rd_enable = (state == st_read) & avail;
  assign consume   = rd_enable;          // Every read uses up one credit.
  assign rd_last   = rd_enable & (scnt == total - 12'd1);
  assign used_w    = cfg_q.used_w;
  assign busy      = (state != st_idle);

  // Setup is captured only when a new frame begins.
  always_ff @(posedge iclk) begin
    if ((state == st_idle) && start) begin
      cfg_q <= cfg;
    end
  end

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      wcnt  <= '0;
      scnt  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_load;
            wcnt  <= '0;
          end
        end
        st_load: begin
          if (wr_en) begin
            wcnt <= wcnt + 8'd1;
            if (last_word) begin
              state <= st_read;  // Reads begin on the next cycle.
              scnt  <= '0;
            end
          end
        end
        st_read: begin
          // Without credit the position simply holds.
          if (rd_enable) begin
            scnt <= scnt + 12'd1;
            if (rd_last) begin
              state <= st_idle;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

/* hw/ldpc_enc_credit_cnt.sv */
// Credit counter for the downstream slice stream.
// Holds how many more slices the consumer can take. Each issued read
// takes one credit and each returned pulse gives one back.

`timescale 1ns/1ps

module ldpc_enc_credit_cnt #(
  parameter int credits = 4
) (
  input  logic iclk,
  input  logic arst_n,
  input  logic consume,
  input  logic credit_ret,
  output logic avail
);

  localparam int cnt_w = $clog2(credits + 1);  // Wide enough to hold the full count.

  logic [cnt_w-1:0] cnt;  // Free credits.

  // The consumer starts out with room for credits slices.
  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= cnt_w'(credits);
    end else begin
      case ({consume, credit_ret})
        2'b10: begin
          cnt <= cnt - 1'b1;  // One more slice in flight.
        end
        2'b01: begin
          cnt <= cnt + 1'b1;  // Consumer retired a slice.
        end
        default: begin
          cnt <= cnt;  // Both or neither, so the count stays.
        end
      endcase
    end
  end

  // The controller only reads when at least one credit is left.
  assign avail = (cnt != '0);

endmodule

/* hw/enc_buf/ldpc_enc_raddr_gen.sv */
// Read address generator for the encoder buffer RAM.
// Every read enable is one slice read. In variable width mode the address
// moves on only after the last slice of a word, in fixed mode on every read.
// A delay line carries valid, last and word start in step with the RAM data.

`timescale 1ns/1ps

module ldpc_enc_raddr_gen #(
  parameter int addr_w        = 8,
  parameter bit use_var_dat_w = 1
) (
  input  logic                  iclk,
  input  logic                  arst_n,
  input  ldpc_enc_pkg::used_w_t used_w,
  input  logic                  rd_clear,
  input  logic                  rd_enable,
  input  logic                  rd_last,
  output logic [addr_w-1:0]     raddr,
  output logic                  rval,
  output logic                  rlast,
  output logic                  rword_start
);

  import ldpc_enc_pkg::*;

  // Tag that travels alongside each read through the RAM latency.
  typedef struct packed {
    logic val;
    logic last;
    logic word_start;
  } rd_tag_t;

  logic          word_start;  // This read takes the first slice of a word.
  logic          word_end;    // This read takes the last slice of a word.
  logic          adv_pend;    // Next read moves to the next word.
  rd_tag_t       tag_s0;      // Stage aligned with raddr.
  rd_tag_t [1:0] tag_d;       // Two more stages to match the RAM.

  generate
    if (use_var_dat_w) begin : g_var
      logic [log2_dat_w:0] acc;  // Bits of the word consumed, this read included.

      assign word_start = (acc == used_w);  // Only the first read of a word holds one width.
      assign word_end   = acc[log2_dat_w];  // Top bit set once a full word is used.

      always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
          acc <= '0;
        end else if (rd_clear) begin
          acc <= used_w;
        end else if (rd_enable) begin
          acc <= word_end ? used_w : acc + used_w;  // Reload on a new word.
        end
      end
    end else begin : g_fix
      // One read per word, so each read both opens and closes a word.
      assign word_start = 1'b1;
      assign word_end   = 1'b1;
    end
  endgenerate

  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      raddr    <= '0;
      adv_pend <= 1'b0;
      tag_s0   <= '0;
      tag_d    <= '0;
    end else begin
      tag_s0.val        <= rd_enable & ~rd_clear;
      tag_s0.last       <= rd_enable & ~rd_clear & rd_last;
      tag_s0.word_start <= word_start;
      tag_d             <= {tag_d[0], tag_s0};  // Shift toward the RAM output.
      if (rd_clear) begin
        raddr    <= '0;  // Frame restarts at word zero.
        adv_pend <= 1'b0;
      end else if (rd_enable) begin
        // The address for this read is presented now, the step for a
        // finished word is applied on the following read.
        raddr    <= raddr + addr_w'(adv_pend);
        adv_pend <= word_end;
      end
    end
  end

  // RAM data lands two edges after raddr, and so does the tag.
  assign rval        = tag_d[1].val;
  assign rlast       = tag_d[1].last;
  assign rword_start = tag_d[1].word_start;

endmodule

/* hw/enc_buf/ldpc_enc_buf_ram.sv */
// Frame buffer RAM for the LDPC encoder input side.
// Simple dual-port memory, one write and one read port on the same clock.
// Both the read address and the read data are registered, so data for an
// address presented at one edge appears two edges later.

`timescale 1ns/1ps

module ldpc_enc_buf_ram #(
  parameter int addr_w = 8
) (
  input  logic                           iclk,
  input  logic                           arst_n,
  input  logic                           wr_en,
  input  logic [addr_w-1:0]              wr_addr,
  input  logic [ldpc_enc_pkg::dat_w-1:0] wr_data,
  input  logic [addr_w-1:0]              raddr,
  output logic [ldpc_enc_pkg::dat_w-1:0] rdata
);

  import ldpc_enc_pkg::*;

  logic [dat_w-1:0]  mem [2**addr_w];  // Word storage for one frame.
  logic [addr_w-1:0] raddr_q;          // First read stage.

  // Write port. A word written at an edge is readable from the next edge on.
  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port with address and output registers.
  always_ff @(posedge iclk or negedge arst_n) begin
    if (!arst_n) begin
      raddr_q <= '0;
      rdata   <= '0;
    end else begin
      raddr_q <= raddr;         // Latency stage one.
      rdata   <= mem[raddr_q];  // Latency stage two.
    end
  end

endmodule

/* common/ldpc_enc_pkg.sv */
// LDPC encoder input buffer shared definitions.
// Holds the RAM word width, the slice width type and the structs that
// carry frame configuration, input words and output slices between blocks.

package ldpc_enc_pkg;

  // Buffer RAM word width in bits.
  localparam int dat_w = 8;

  // Number of bits needed to count the bits of one word, minus one.
  localparam int log2_dat_w = 3;

  // Slice width taken per read.
  // Legal values are 1, 2, 4 and 8; one extra bit so that 8 fits.
  typedef logic [log2_dat_w:0] used_w_t;

  // Frame setup, sampled by the controller when start is seen in idle.
  typedef struct packed {
    logic [7:0] num_words;  // Words in the frame, 0 stands for 256.
    used_w_t    used_w;     // Slice width for the whole frame.
  } frame_cfg_t;

  // One incoming RAM word from the writer.
  typedef struct packed {
    logic             valid;  // Word present this cycle.
    logic [dat_w-1:0] data;   // Word payload.
  } in_word_t;

  // One outgoing slice toward the downstream consumer.
  // Slice bits sit at the low end of data, the upper bits are zero.
  typedef struct packed {
    logic             valid;  // Slice present this cycle.
    logic             last;   // Final slice of the frame.
    logic [dat_w-1:0] data;   // Slice bits, zero padded.
  } out_slice_t;

endpackage
